/* dcache_subsys.f */
rtl/cache_interface_types.sv
rtl/lsu_types_pkg.sv
rtl/store_buffer_ifs.sv
rtl/access_align.sv
rtl/store_buffer.sv
rtl/dcache_array.sv
rtl/load_return.sv
rtl/dcache_subsys.sv
verification/tb_dcache_subsys.sv

/* rtl/access_align.sv */
`timescale 1ns/1ns

module access_align #(
	parameter int ADDR_BITS = 12
) (
	input  logic                                   store_i,
	input  logic [ADDR_BITS-1:0]                   store_addr_i,
	input  logic [31:0]                            store_data_i,
	input  cache_interface_types::cache_access_size_t store_size_i,
	input  logic [ADDR_BITS-1:0]                   load_addr_i,
	input  cache_interface_types::cache_access_size_t load_size_i,
	sb_put_if.sender                               put,
	sb_snoop_if.requester                          snoop
);

	// Store request
	assign put.put  = store_i;
	assign put.addr = store_addr_i;
	assign put.size = store_size_i;

	// Move the low byte or halfword into the lane the address picks
	always_comb begin
		cache_interface_types::word_lanes_u lanes;
		lanes.word = '0;
		unique case (store_size_i)
			cache_interface_types::ACCESS_BYTE:
				lanes.bytes[store_addr_i[1:0]] = store_data_i[7:0];
			cache_interface_types::ACCESS_HALF:
				lanes.half[store_addr_i[1]] = store_data_i[15:0];
			default:
				lanes.word = store_data_i;
		endcase
		put.data = lanes.word;
	end

	// Load lookup goes straight to the buffer
	assign snoop.addr = load_addr_i;
	assign snoop.size = load_size_i;

endmodule

/* rtl/cache_interface_types.sv */
package cache_interface_types;

	// Access width of a load or store
	typedef enum logic [1:0] {
		ACCESS_BYTE = 2'd0,
		ACCESS_HALF = 2'd1,
		ACCESS_WORD = 2'd2
	} cache_access_size_t;

	// One data word seen as a whole, as halfword lanes or as byte lanes
	typedef union packed {
		logic [31:0]      word;
		logic [1:0][15:0] half;
		logic [3:0][7:0]  bytes;
	} word_lanes_u;

endpackage

/* rtl/dcache_array.sv */
`timescale 1ns/1ns

module dcache_array #(
	parameter int ADDR_BITS = 12
) (
	input  logic                 clk_i,
	input  logic                 reset_i,
	input  logic                 load_accept_i,
	input  logic [ADDR_BITS-1:0] load_addr_i,
	sb_drain_if.sink             drain,
	output logic [31:0]          rd_word_o
);

	localparam int WORDS = 2 ** (ADDR_BITS - 2);

	logic [3:0][7:0] mem [WORDS];

	cache_interface_types::word_lanes_u wr_lanes;
	logic [3:0]                         byte_en;
	logic [ADDR_BITS-3:0]               wr_idx;

	// Loads own the port, the drain takes it when free
	assign drain.accept = drain.valid && !load_accept_i;

	assign wr_lanes.word = drain.data;
	assign wr_idx        = drain.addr[ADDR_BITS-1:2];

	always_comb begin
		unique case (drain.size)
			cache_interface_types::ACCESS_BYTE:
				byte_en = 4'b0001 << drain.addr[1:0];
			cache_interface_types::ACCESS_HALF:
				byte_en = 4'b0011 << {drain.addr[1], 1'b0};
			default:
				byte_en = 4'b1111;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Byte-enabled drain write
	always_ff @(posedge clk_i) begin
		if (drain.accept) begin
			for (int b = 0; b < 4; b++) begin
				if (byte_en[b])
					mem[wr_idx][b] <= wr_lanes.bytes[b];
			end
		end
	end

	// Synchronous full-word read
	always_ff @(posedge clk_i) begin
		if (reset_i)
			rd_word_o <= '0;
		else if (load_accept_i)
			rd_word_o <= mem[load_addr_i[ADDR_BITS-1:2]];
	end

endmodule

/* rtl/dcache_subsys.sv */
`timescale 1ns/1ns

module dcache_subsys #(
	parameter int NUM_ENTRIES = 4,
	parameter int ADDR_BITS   = 12,
	parameter int LINE_BYTES  = 32
) (
	input  logic                                   clk_i,
	input  logic                                   reset_i,
	input  logic                                   store_i,
	input  logic [ADDR_BITS-1:0]                   store_addr_i,
	input  logic [31:0]                            store_data_i,
	input  cache_interface_types::cache_access_size_t store_size_i,
	input  logic                                   load_i,
	input  logic [ADDR_BITS-1:0]                   load_addr_i,
	input  cache_interface_types::cache_access_size_t load_size_i,
	output logic                                   load_stall_o,
	output logic [31:0]                            load_data_o,
	output logic                                   load_valid_o,
	output logic                                   full_o,
	output logic                                   empty_o
);

	sb_put_if   #(.ADDR_BITS(ADDR_BITS)) put_bus ();
	sb_snoop_if #(.ADDR_BITS(ADDR_BITS)) snoop_bus ();
	sb_drain_if #(.ADDR_BITS(ADDR_BITS)) drain_bus ();

	logic        load_accept;
	logic [31:0] rd_word;

	// Line conflict holds the load until the buffer drains past it
	assign load_stall_o = load_i && snoop_bus.conflict;
	assign load_accept  = load_i && !snoop_bus.conflict;

	access_align #(.ADDR_BITS(ADDR_BITS)) u_align (
		.store_i      (store_i),
		.store_addr_i (store_addr_i),
		.store_data_i (store_data_i),
		.store_size_i (store_size_i),
		.load_addr_i  (load_addr_i),
		.load_size_i  (load_size_i),
		.put          (put_bus.sender),
		.snoop        (snoop_bus.requester)
	);

	store_buffer #(
		.NUM_ENTRIES (NUM_ENTRIES),
		.ADDR_BITS   (ADDR_BITS),
		.LINE_BYTES  (LINE_BYTES)
	) u_store_buffer (
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.put     (put_bus.receiver),
		.snoop   (snoop_bus.responder),
		.drain   (drain_bus.source),
		.full_o  (full_o),
		.empty_o (empty_o)
	);

	dcache_array #(.ADDR_BITS(ADDR_BITS)) u_array (
		.clk_i         (clk_i),
		.reset_i       (reset_i),
		.load_accept_i (load_accept),
		.load_addr_i   (load_addr_i),
		.drain         (drain_bus.sink),
		.rd_word_o     (rd_word)
	);

	load_return u_load_return (
		.clk_i         (clk_i),
		.reset_i       (reset_i),
		.load_accept_i (load_accept),
		.load_addr_i   (load_addr_i[1:0]),
		.load_size_i   (load_size_i),
		.rd_word_i     (rd_word),
		.snoop         (snoop_bus.monitor),
		.load_data_o   (load_data_o),
		.load_valid_o  (load_valid_o)
	);

endmodule

/* rtl/load_return.sv */
`timescale 1ns/1ns

module load_return (
	input  logic                                   clk_i,
	input  logic                                   reset_i,
	input  logic                                   load_accept_i,
	input  logic [1:0]                             load_addr_i,
	input  cache_interface_types::cache_access_size_t load_size_i,
	input  logic [31:0]                            rd_word_i,
	sb_snoop_if.monitor                            snoop,
	output logic [31:0]                            load_data_o,
	output logic                                   load_valid_o
);

	logic                                      valid_q;
	lsu_types_pkg::load_source_t               src_q;
	logic [31:0]                               fwd_q;
	cache_interface_types::cache_access_size_t size_q;
	logic [1:0]                                lane_q;

	always_ff @(posedge clk_i) begin
		if (reset_i)
			valid_q <= 1'b0;
		else
			valid_q <= load_accept_i;
	end

	// Capture everything the return needs at acceptance
	always_ff @(posedge clk_i) begin
		if (load_accept_i) begin
			src_q  <= snoop.source;
			fwd_q  <= snoop.data;
			size_q <= load_size_i;
			lane_q <= load_addr_i;
		end
	end

	assign load_valid_o = valid_q;

	// Pick the word, then pull out the lane, zero extended
	always_comb begin
		cache_interface_types::word_lanes_u lanes;
		lanes.word = (src_q == lsu_types_pkg::SRC_FORWARD) ? fwd_q : rd_word_i;
		unique case (size_q)
			cache_interface_types::ACCESS_BYTE:
				load_data_o = {24'b0, lanes.bytes[lane_q]};
			cache_interface_types::ACCESS_HALF:
				load_data_o = {16'b0, lanes.half[lane_q[1]]};
			default:
				load_data_o = lanes.word;
		endcase
	end

endmodule

/* rtl/lsu_types_pkg.sv */
package lsu_types_pkg;

	// Where a returning load takes its data from
	typedef enum logic {
		SRC_ARRAY   = 1'b0,
		SRC_FORWARD = 1'b1
	} load_source_t;

endpackage

/* rtl/store_buffer.sv */
`timescale 1ns/1ns

module store_buffer #(
	parameter int NUM_ENTRIES = 4,
	parameter int ADDR_BITS   = 12,
	parameter int LINE_BYTES  = 32
) (
	input  logic          clk_i,
	input  logic          reset_i,
	sb_put_if.receiver    put,
	sb_snoop_if.responder snoop,
	sb_drain_if.source    drain,
	output logic          full_o,
	output logic          empty_o
);

	localparam int IDX_BITS    = $clog2(NUM_ENTRIES);
	localparam int OFFSET_BITS = $clog2(LINE_BYTES);

	typedef struct packed {
		logic [ADDR_BITS-1:0]                   addr;
		logic [31:0]                            data;
		cache_interface_types::cache_access_size_t size;
	} sb_entry_t;

	sb_entry_t           entries [NUM_ENTRIES];
	logic [IDX_BITS-1:0] head;
	logic [IDX_BITS-1:0] tail;
	logic                full;

	logic empty;
	logic advance;
	logic retire;

	function automatic logic [IDX_BITS-1:0] next_ptr(input logic [IDX_BITS-1:0] p);
		return (p == IDX_BITS'(NUM_ENTRIES - 1)) ? '0 : p + 1'b1;
	endfunction

	assign empty   = !full && (head == tail);
	assign advance = put.put && !full;
	assign retire  = drain.valid && drain.accept;

	assign full_o  = full;
	assign empty_o = empty;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Drain side, oldest entry sits at tail
	assign drain.valid = !empty;
	assign drain.addr  = entries[tail].addr;
	assign drain.data  = entries[tail].data;
	assign drain.size  = entries[tail].size;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Snoop, oldest to youngest so the last match wins
	always_comb begin
		int count;
		int idx;
		if (full)
			count = NUM_ENTRIES;
		else if (head >= tail)
			count = int'(head) - int'(tail);
		else
			count = int'(head) + NUM_ENTRIES - int'(tail);
		snoop.data     = '0;
		snoop.hit      = 1'b0;
		snoop.conflict = 1'b0;
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			idx = (int'(tail) + i) % NUM_ENTRIES;
			if (i < count) begin
				if (entries[idx].addr == snoop.addr &&
				    entries[idx].size == snoop.size) begin
					snoop.hit      = 1'b1;
					snoop.conflict = 1'b0;
					snoop.data     = entries[idx].data;
				end else if (entries[idx].addr[ADDR_BITS-1:OFFSET_BITS] ==
				             snoop.addr[ADDR_BITS-1:OFFSET_BITS]) begin
					snoop.hit      = 1'b0;
					snoop.conflict = 1'b1;
				end
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Pointers and full flag
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			head <= '0;
			tail <= '0;
			full <= 1'b0;
		end else begin
			if (advance)
				head <= next_ptr(head);
			if (retire)
				tail <= next_ptr(tail);
			// Count is unchanged when both happen
			if (retire)
				full <= 1'b0;
			else if (advance)
				full <= (next_ptr(head) == tail);
		end
	end

	always_ff @(posedge clk_i) begin
		if (advance) begin
			entries[head].addr <= put.addr;
			entries[head].data <= put.data;
			entries[head].size <= put.size;
		end
	end

endmodule

/* rtl/store_buffer_ifs.sv */
`timescale 1ns/1ns

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Store entry into the buffer
interface sb_put_if #(parameter int ADDR_BITS = 12);
	logic [ADDR_BITS-1:0]                   addr;
	logic [31:0]                            data;
	cache_interface_types::cache_access_size_t size;
	logic                                   put;

	modport sender   (output addr, data, size, put);
	modport receiver (input addr, data, size, put);
endinterface

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Load lookup against buffered stores
interface sb_snoop_if #(parameter int ADDR_BITS = 12);
	logic [ADDR_BITS-1:0]                   addr;
	cache_interface_types::cache_access_size_t size;
	logic [31:0]                            data;
	logic                                   hit;
	logic                                   conflict;
	lsu_types_pkg::load_source_t            source;

	// A hit means the data comes from the buffer
	assign source = hit ? lsu_types_pkg::SRC_FORWARD : lsu_types_pkg::SRC_ARRAY;

	modport requester (output addr, size);
	modport responder (input addr, size, output data, hit, conflict);
	modport monitor   (input data, source);
endinterface

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Oldest entry towards the data array
interface sb_drain_if #(parameter int ADDR_BITS = 12);
	logic [ADDR_BITS-1:0]                   addr;
	logic [31:0]                            data;
	cache_interface_types::cache_access_size_t size;
	logic                                   valid;
	logic                                   accept;

	modport source (output addr, data, size, valid, input accept);
	modport sink   (input addr, data, size, valid, output accept);
endinterface

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_dcache_subsys -f dcache_subsys.f -o tb_dcache_subsys &&
./obj_dir/tb_dcache_subsys | tee /dev/stderr | grep -qx "NO ERRORS" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

/* verification/tb_dcache_subsys.sv */
`timescale 1ns/1ns

module tb_dcache_subsys;

	localparam int NUM_ENTRIES   = 4;
	localparam int ADDR_BITS     = 12;
	localparam int LINE_BYTES    = 32;
	localparam int RUN_CYCLES    = 2000;
	localparam int TIMEOUT_NS    = (RUN_CYCLES + 200) * 20;
	localparam int WIN_BYTES     = 128;
	localparam int STALL_LIMIT   = 2 * NUM_ENTRIES + 2;
	localparam int MODE_RANDOM   = 0;
	localparam int MODE_BURST    = 1;
	localparam int MODE_PRESSURE = 2;
	localparam int MODE_SETTLE   = 3;

	logic                                      clk_i        = 1'b0;
	logic                                      reset_i      = 1'b1;
	logic                                      store_i      = 1'b0;
	logic [ADDR_BITS-1:0]                      store_addr_i = '0;
	logic [31:0]                               store_data_i = '0;
	cache_interface_types::cache_access_size_t store_size_i = cache_interface_types::ACCESS_WORD;
	logic                                      load_i       = 1'b0;
	logic [ADDR_BITS-1:0]                      load_addr_i  = '0;
	cache_interface_types::cache_access_size_t load_size_i  = cache_interface_types::ACCESS_WORD;
	logic                                      load_stall_o;
	logic [31:0]                               load_data_o;
	logic                                      load_valid_o;
	logic                                      full_o;
	logic                                      empty_o;

	// Next cycle's stimulus, applied on the rising edge
	logic                                      nx_store = 1'b0;
	logic [ADDR_BITS-1:0]                      nx_addr  = '0;
	logic [31:0]                               nx_data  = '0;
	cache_interface_types::cache_access_size_t nx_size  = cache_interface_types::ACCESS_WORD;
	logic                                      nx_load  = 1'b0;
	logic [ADDR_BITS-1:0]                      nx_laddr = '0;
	cache_interface_types::cache_access_size_t nx_lsize = cache_interface_types::ACCESS_WORD;
	logic [ADDR_BITS-1:0]                      last_addr = '0;
	cache_interface_types::cache_access_size_t last_size = cache_interface_types::ACCESS_WORD;

	// Buffered stores in arrival order
	logic [ADDR_BITS-1:0]                      sb_addr_q [$];
	cache_interface_types::cache_access_size_t sb_size_q [$];

	logic [7:0]  model_mem [WIN_BYTES];
	logic [31:0] expect_q [$];
	logic        valid_due = 1'b0;
	logic        saw_full  = 1'b0;
	logic        done      = 1'b0;
	int          occ = 0;
	int          cycle = 0;
	int          init_idx = 0;
	int          stall_run = 0;
	int          mode = MODE_RANDOM;
	int          mode_left = 0;
	int          mismatch_count = 0;
	int          failure_count = 0;

	dcache_subsys #(
		.NUM_ENTRIES (NUM_ENTRIES),
		.ADDR_BITS   (ADDR_BITS),
		.LINE_BYTES  (LINE_BYTES)
	) i_dut (.*);

	always #10 clk_i = ~clk_i;

	function automatic cache_interface_types::cache_access_size_t pick_size();
		logic [1:0] s;
		s = 2'($urandom % 3);
		return cache_interface_types::cache_access_size_t'(s);
	endfunction

	function automatic logic [ADDR_BITS-1:0] aligned_addr(input int base, input int span,
			input cache_interface_types::cache_access_size_t size);
		int a;
		a = base + int'($urandom % 32'(span));
		if (size == cache_interface_types::ACCESS_HALF)
			a = a & ~1;
		else if (size == cache_interface_types::ACCESS_WORD)
			a = a & ~3;
		return ADDR_BITS'(a);
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Byte memory model, little endian, loads zero extended
	function automatic logic [31:0] model_read(input int a,
			input cache_interface_types::cache_access_size_t size);
		case (size)
			cache_interface_types::ACCESS_BYTE: return {24'b0, model_mem[a]};
			cache_interface_types::ACCESS_HALF: return {16'b0, model_mem[a+1], model_mem[a]};
			default: return {model_mem[a+3], model_mem[a+2], model_mem[a+1], model_mem[a]};
		endcase
	endfunction

	task automatic model_write(input int a, input cache_interface_types::cache_access_size_t size,
			input logic [31:0] data);
		model_mem[a] = data[7:0];
		if (size != cache_interface_types::ACCESS_BYTE)
			model_mem[a+1] = data[15:8];
		if (size == cache_interface_types::ACCESS_WORD) begin
			model_mem[a+2] = data[23:16];
			model_mem[a+3] = data[31:24];
		end
	endtask

	// Youngest buffered store in the load's line decides the stall
	function automatic logic line_conflict(input logic [ADDR_BITS-1:0] a,
			input cache_interface_types::cache_access_size_t size);
		logic found;
		logic conflict;
		found    = 1'b0;
		conflict = 1'b0;
		for (int i = sb_addr_q.size() - 1; i >= 0; i--) begin
			if (!found && (sb_addr_q[i] / LINE_BYTES == a / LINE_BYTES)) begin
				found    = 1'b1;
				conflict = (sb_addr_q[i] != a) || (sb_size_q[i] != size);
			end
		end
		return conflict;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
		$display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, got);
		mismatch_count++;
	endtask

	task automatic report_failure(input string msg);
		$display("Failure at %0t: %s", $time, msg);
		failure_count++;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus for the cycle after the coming edge, occ is the count after that edge
	task automatic plan_next(input logic stalled);
		int r;
		nx_store = 1'b0;
		nx_load  = stalled;
		if (cycle >= RUN_CYCLES) begin
			nx_load = 1'b0;
			return;
		end
		if (stalled)
			return;
		// Fill the window first so every load reads known data
		if (init_idx < WIN_BYTES / 4) begin
			nx_store = 1'b1;
			nx_size  = cache_interface_types::ACCESS_WORD;
			nx_addr  = ADDR_BITS'(init_idx * 4);
			init_idx++;
		end else begin
			if (mode_left == 0) begin
				r = int'($urandom % 16);
				mode      = (r < 2) ? MODE_PRESSURE : (r < 5) ? MODE_BURST :
				            (r < 6) ? MODE_SETTLE : MODE_RANDOM;
				mode_left = (mode == MODE_PRESSURE) ? 20 : (mode == MODE_SETTLE) ? 1 : 10;
			end
			nx_size = pick_size();
			case (mode)
				MODE_PRESSURE: begin
					// Loads in the upper lines, stores in the lower ones
					nx_load  = 1'b1;
					nx_lsize = pick_size();
					nx_laddr = aligned_addr(WIN_BYTES / 2, WIN_BYTES / 2, nx_lsize);
					nx_store = (occ != NUM_ENTRIES);
					nx_addr  = aligned_addr(0, WIN_BYTES / 2, nx_size);
					mode_left--;
				end
				MODE_BURST: begin
					nx_load  = 1'b1;
					nx_laddr = last_addr;
					nx_lsize = last_size;
					nx_store = (occ != NUM_ENTRIES);
					nx_addr  = aligned_addr(0, WIN_BYTES, nx_size);
					mode_left--;
				end
				MODE_SETTLE: begin
					if (occ == 0) begin
						nx_load   = 1'b1;
						nx_lsize  = cache_interface_types::ACCESS_WORD;
						nx_laddr  = aligned_addr(0, WIN_BYTES, nx_lsize);
						mode_left = 0;
					end
				end
				default: begin
					nx_load  = $urandom % 2 == 0;
					nx_lsize = pick_size();
					nx_laddr = aligned_addr(0, WIN_BYTES, nx_lsize);
					nx_store = (occ != NUM_ENTRIES) && ($urandom % 2 == 0);
					nx_addr  = aligned_addr(0, WIN_BYTES, nx_size);
					mode_left--;
				end
			endcase
		end
		if (nx_store) begin
			nx_data   = $urandom;
			last_addr = nx_addr;
			last_size = nx_size;
		end
	endtask

	always @(posedge clk_i) begin
		store_i      <= nx_store;
		store_addr_i <= nx_addr;
		store_data_i <= nx_data;
		store_size_i <= nx_size;
		load_i       <= nx_load;
		load_addr_i  <= nx_laddr;
		load_size_i  <= nx_lsize;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks at the falling edge, then the outcome of the coming rising edge
	always @(negedge clk_i) begin : check_and_plan
		logic        load_acc;
		logic        store_acc;
		logic        retire;
		logic        exp_stall;
		logic [31:0] exp_val;
		if (!reset_i && !done) begin
			if (load_valid_o !== valid_due)
				report_mismatch("load_valid_o", 32'(valid_due), 32'(load_valid_o));
			if (valid_due) begin
				exp_val = expect_q.pop_front();
				if (load_valid_o === 1'b1 && load_data_o !== exp_val)
					report_mismatch("load_data_o", exp_val, load_data_o);
			end
			if (full_o !== (occ == NUM_ENTRIES))
				report_mismatch("full_o", 32'(occ == NUM_ENTRIES), 32'(full_o));
			if (empty_o !== (occ == 0))
				report_mismatch("empty_o", 32'(occ == 0), 32'(empty_o));
			exp_stall = load_i && line_conflict(load_addr_i, load_size_i);
			if (load_stall_o !== exp_stall)
				report_mismatch("load_stall_o", 32'(exp_stall), 32'(load_stall_o));
			if (empty_o === 1'b1 && load_stall_o === 1'b1)
				report_failure("load_stall_o rose while the store buffer was empty");

			load_acc  = load_i && !exp_stall;
			store_acc = store_i && (occ != NUM_ENTRIES);
			// Drain only gets the port on edges without an accepted load
			retire    = (occ != 0) && !load_acc;
			if (load_acc)
				expect_q.push_back(model_read(int'(load_addr_i), load_size_i));
			valid_due = load_acc;
			if (retire) begin
				sb_addr_q.delete(0);
				sb_size_q.delete(0);
			end
			if (store_acc) begin
				model_write(int'(store_addr_i), store_size_i, store_data_i);
				sb_addr_q.push_back(store_addr_i);
				sb_size_q.push_back(store_size_i);
			end
			occ = sb_addr_q.size();
			if (occ == NUM_ENTRIES)
				saw_full = 1'b1;

			stall_run = (load_i && load_stall_o) ? stall_run + 1 : 0;
			if (stall_run == STALL_LIMIT)
				report_failure($sformatf("a stalled load was not accepted within %0d cycles",
				                         STALL_LIMIT));
			plan_next(load_i && load_stall_o);
			cycle++;

			if (cycle == RUN_CYCLES + 4) begin
				if (!saw_full)
					report_failure("full_o never rose during back-to-back loads");
				done = 1'b1;
			end
		end
	end

	initial begin : main_sequence
		int seed_ret;
		seed_ret = $urandom(32'h71230927);
		repeat (3) @(posedge clk_i);
		reset_i <= 1'b0;
		wait (done);
		$display("Run complete: %0d mismatches, %0d other failures", mismatch_count, failure_count);
		if (mismatch_count + failure_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	initial begin : watchdog
		#(TIMEOUT_NS);
		$display("Watchdog expired at %0t, the run did not complete", $time);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule
